// File: div_pkg.sv
// ==================================================
// Shared widths, stage counts and vector types for
// the pipelined radix-2 divider. Modules refer to
// these by scoped names.
// ==================================================

package div_pkg;

	// Operand width
	localparam int data_width = 32;

	// Quotient bits resolved per stage
	localparam int bits_per_stage = 2;

	// One stage per pair of dividend bits
	localparam int stage_count = data_width / bits_per_stage;

	// Operand prep, stage chain, sign fix
	localparam int div_latency = stage_count + 2;

	// Dividend, divisor, quotient or remainder
	typedef logic [data_width-1:0] data_t;

	// Quotient bits from one stage
	typedef logic [bits_per_stage-1:0] step_t;

endpackage

// File: div_operand_prep.sv
// ==================================================
// Operand preparation for the divider. Registers the
// operand magnitudes with the result sign flags and
// the valid strobe, one cycle after the input.
// ==================================================

`timescale 1ns/10ps

module div_operand_prep (
	input  logic          clock,
	input  logic          reset,
	input  logic          remove,
	input  logic          in_valid,
	input  logic          in_signed,
	input  div_pkg::data_t in_dividend,
	input  div_pkg::data_t in_divisor,
	output logic          prep_valid,
	output logic          prep_neg_q,
	output logic          prep_neg_r,
	output div_pkg::data_t prep_dividend,
	output div_pkg::data_t prep_divisor
);

	logic dividend_neg;
	logic divisor_neg;
	div_pkg::data_t dividend_mag;
	div_pkg::data_t divisor_mag;

	// Sign bits only count in signed mode
	assign dividend_neg = in_signed & in_dividend[div_pkg::data_width-1];
	assign divisor_neg  = in_signed & in_divisor[div_pkg::data_width-1];

	assign dividend_mag = dividend_neg ? (~in_dividend + 1'b1) : in_dividend;
	assign divisor_mag  = divisor_neg ? (~in_divisor + 1'b1) : in_divisor;

	always_ff @(posedge clock) begin
		if (reset || remove) begin
			prep_valid <= 1'b0;
		end else begin
			prep_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		prep_dividend <= dividend_mag;
		prep_divisor  <= divisor_mag;
		// Quotient negative on differing signs, remainder follows dividend
		prep_neg_q    <= dividend_neg ^ divisor_neg;
		prep_neg_r    <= dividend_neg;
	end

endmodule

// File: div_stage.sv
// ==================================================
// One divider pipeline stage. Runs two restoring
// steps on the next pair of dividend bits, chosen by
// stage_index from the top, and registers the result.
// ==================================================

`timescale 1ns/10ps

module div_stage #(
	parameter int stage_index = 0
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          remove,
	input  logic          stage_in_valid,
	input  logic          stage_in_neg_q,
	input  logic          stage_in_neg_r,
	input  div_pkg::data_t stage_in_dividend,
	input  div_pkg::data_t stage_in_divisor,
	input  div_pkg::data_t stage_in_remainder,
	input  div_pkg::data_t stage_in_quotient,
	output logic          stage_out_valid,
	output logic          stage_out_neg_q,
	output logic          stage_out_neg_r,
	output div_pkg::data_t stage_out_dividend,
	output div_pkg::data_t stage_out_divisor,
	output div_pkg::data_t stage_out_remainder,
	output div_pkg::data_t stage_out_quotient
);

	// Highest dividend bit consumed here
	localparam int top_bit =
		div_pkg::data_width - 1 - stage_index * div_pkg::bits_per_stage;

	logic [div_pkg::data_width:0]   shifted;
	logic [div_pkg::data_width+1:0] trial;
	div_pkg::data_t next_remainder;
	div_pkg::step_t next_bits;

	always_comb begin
		next_remainder = stage_in_remainder;
		next_bits      = '0;
		shifted        = '0;
		trial          = '0;
		for (int step = 0; step < div_pkg::bits_per_stage; step++) begin
			shifted = {next_remainder, stage_in_dividend[top_bit-step]};
			trial   = {1'b0, shifted} - {2'b00, stage_in_divisor};
			// Restore when the trial goes negative
			if (trial[div_pkg::data_width+1]) begin
				next_bits[div_pkg::bits_per_stage-1-step] = 1'b0;
				next_remainder = shifted[div_pkg::data_width-1:0];
			end else begin
				next_bits[div_pkg::bits_per_stage-1-step] = 1'b1;
				next_remainder = trial[div_pkg::data_width-1:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset || remove) begin
			stage_out_valid <= 1'b0;
		end else begin
			stage_out_valid <= stage_in_valid;
		end
	end

	always_ff @(posedge clock) begin
		stage_out_neg_q     <= stage_in_neg_q;
		stage_out_neg_r     <= stage_in_neg_r;
		stage_out_dividend  <= stage_in_dividend;
		stage_out_divisor   <= stage_in_divisor;
		stage_out_remainder <= next_remainder;
		stage_out_quotient  <= {stage_in_quotient[div_pkg::data_width-div_pkg::bits_per_stage-1:0],
			next_bits};
	end

endmodule

// File: div_pipeline.sv
// ==================================================
// Divider stage chain. Takes prepared magnitudes and
// returns the unsigned quotient and remainder with
// their sign flags after one cycle per stage.
// ==================================================

`timescale 1ns/10ps

module div_pipeline (
	input  logic          clock,
	input  logic          reset,
	input  logic          remove,
	input  logic          prep_valid,
	input  logic          prep_neg_q,
	input  logic          prep_neg_r,
	input  div_pkg::data_t prep_dividend,
	input  div_pkg::data_t prep_divisor,
	output logic          raw_valid,
	output logic          raw_neg_q,
	output logic          raw_neg_r,
	output div_pkg::data_t raw_quotient,
	output div_pkg::data_t raw_remainder
);

	// Entry k feeds stage k, the last entry is the chain output
	logic           valid_chain     [0:div_pkg::stage_count];
	logic           neg_q_chain     [0:div_pkg::stage_count];
	logic           neg_r_chain     [0:div_pkg::stage_count];
	div_pkg::data_t dividend_chain  [0:div_pkg::stage_count];
	div_pkg::data_t divisor_chain   [0:div_pkg::stage_count];
	div_pkg::data_t remainder_chain [0:div_pkg::stage_count];
	div_pkg::data_t quotient_chain  [0:div_pkg::stage_count];

	assign valid_chain[0]     = prep_valid;
	assign neg_q_chain[0]     = prep_neg_q;
	assign neg_r_chain[0]     = prep_neg_r;
	assign dividend_chain[0]  = prep_dividend;
	assign divisor_chain[0]   = prep_divisor;
	// Partial remainder and quotient start empty
	assign remainder_chain[0] = '0;
	assign quotient_chain[0]  = '0;

	for (genvar k = 0; k < div_pkg::stage_count; k++) begin : g_stage
		div_stage #(
			.stage_index(k)
		) stage_i (
			.clock              (clock),
			.reset              (reset),
			.remove             (remove),
			.stage_in_valid     (valid_chain[k]),
			.stage_in_neg_q     (neg_q_chain[k]),
			.stage_in_neg_r     (neg_r_chain[k]),
			.stage_in_dividend  (dividend_chain[k]),
			.stage_in_divisor   (divisor_chain[k]),
			.stage_in_remainder (remainder_chain[k]),
			.stage_in_quotient  (quotient_chain[k]),
			.stage_out_valid    (valid_chain[k+1]),
			.stage_out_neg_q    (neg_q_chain[k+1]),
			.stage_out_neg_r    (neg_r_chain[k+1]),
			.stage_out_dividend (dividend_chain[k+1]),
			.stage_out_divisor  (divisor_chain[k+1]),
			.stage_out_remainder(remainder_chain[k+1]),
			.stage_out_quotient (quotient_chain[k+1])
		);
	end

	assign raw_valid     = valid_chain[div_pkg::stage_count];
	assign raw_neg_q     = neg_q_chain[div_pkg::stage_count];
	assign raw_neg_r     = neg_r_chain[div_pkg::stage_count];
	assign raw_quotient  = quotient_chain[div_pkg::stage_count];
	assign raw_remainder = remainder_chain[div_pkg::stage_count];

endmodule

// File: div_result_fix.sv
// ==================================================
// Result sign correction for the divider. Negates
// the raw quotient and remainder as flagged and
// registers them with the output strobe.
// ==================================================

`timescale 1ns/10ps

module div_result_fix (
	input  logic          clock,
	input  logic          reset,
	input  logic          remove,
	input  logic          raw_valid,
	input  logic          raw_neg_q,
	input  logic          raw_neg_r,
	input  div_pkg::data_t raw_quotient,
	input  div_pkg::data_t raw_remainder,
	output logic          out_valid,
	output div_pkg::data_t out_quotient,
	output div_pkg::data_t out_remainder
);

	div_pkg::data_t fixed_quotient;
	div_pkg::data_t fixed_remainder;

	assign fixed_quotient  = raw_neg_q ? (~raw_quotient + 1'b1) : raw_quotient;
	assign fixed_remainder = raw_neg_r ? (~raw_remainder + 1'b1) : raw_remainder;

	always_ff @(posedge clock) begin
		if (reset || remove) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= raw_valid;
		end
	end

	// Results hold between strobes, zero out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			out_quotient  <= '0;
			out_remainder <= '0;
		end else if (raw_valid) begin
			out_quotient  <= fixed_quotient;
			out_remainder <= fixed_remainder;
		end
	end

endmodule

// File: pipelined_div.sv
// ==================================================
// Pipelined radix-2 divider, one division per cycle.
// Quotient and remainder appear div_latency cycles
// after in_valid; remove cancels all in flight.
// ==================================================

`timescale 1ns/10ps

module pipelined_div (
	input  logic          clock,
	input  logic          reset,
	input  logic          remove,
	input  logic          in_valid,
	input  logic          in_signed,
	input  div_pkg::data_t in_dividend,
	input  div_pkg::data_t in_divisor,
	output logic          out_valid,
	output div_pkg::data_t out_quotient,
	output div_pkg::data_t out_remainder
);

	// Operand prep to stage chain
	logic           prep_valid;
	logic           prep_neg_q;
	logic           prep_neg_r;
	div_pkg::data_t prep_dividend;
	div_pkg::data_t prep_divisor;

	// Stage chain to sign fix
	logic           raw_valid;
	logic           raw_neg_q;
	logic           raw_neg_r;
	div_pkg::data_t raw_quotient;
	div_pkg::data_t raw_remainder;

	div_operand_prep prep_i (
		.clock        (clock),
		.reset        (reset),
		.remove       (remove),
		.in_valid     (in_valid),
		.in_signed    (in_signed),
		.in_dividend  (in_dividend),
		.in_divisor   (in_divisor),
		.prep_valid   (prep_valid),
		.prep_neg_q   (prep_neg_q),
		.prep_neg_r   (prep_neg_r),
		.prep_dividend(prep_dividend),
		.prep_divisor (prep_divisor)
	);

	div_pipeline pipeline_i (
		.clock        (clock),
		.reset        (reset),
		.remove       (remove),
		.prep_valid   (prep_valid),
		.prep_neg_q   (prep_neg_q),
		.prep_neg_r   (prep_neg_r),
		.prep_dividend(prep_dividend),
		.prep_divisor (prep_divisor),
		.raw_valid    (raw_valid),
		.raw_neg_q    (raw_neg_q),
		.raw_neg_r    (raw_neg_r),
		.raw_quotient (raw_quotient),
		.raw_remainder(raw_remainder)
	);

	div_result_fix fix_i (
		.clock        (clock),
		.reset        (reset),
		.remove       (remove),
		.raw_valid    (raw_valid),
		.raw_neg_q    (raw_neg_q),
		.raw_neg_r    (raw_neg_r),
		.raw_quotient (raw_quotient),
		.raw_remainder(raw_remainder),
		.out_valid    (out_valid),
		.out_quotient (out_quotient),
		.out_remainder(out_remainder)
	);

endmodule

// File: tb_pipelined_div.sv
// ==================================================
// Self-checking testbench for the pipelined divider.
// Reads operations and expected results from
// div_test_input.txt and checks every result strobe.
// ==================================================

`timescale 1ns/10ps

module tb_pipelined_div;

	localparam int max_lines = 64;
	localparam int op_idle = 0;
	localparam int op_divide = 1;
	localparam int op_flush = 2;

	logic           clock;
	logic           reset;
	logic           remove;
	logic           in_valid;
	logic           in_signed;
	div_pkg::data_t in_dividend;
	div_pkg::data_t in_divisor;
	logic           out_valid;
	div_pkg::data_t out_quotient;
	div_pkg::data_t out_remainder;

	// One entry per data line
	reg [8*16-1:0]  test_name     [0:max_lines-1];
	int             op_code       [0:max_lines-1];
	logic           signed_flag   [0:max_lines-1];
	div_pkg::data_t dividend_v    [0:max_lines-1];
	div_pkg::data_t divisor_v     [0:max_lines-1];
	div_pkg::data_t exp_quotient  [0:max_lines-1];
	div_pkg::data_t exp_remainder [0:max_lines-1];
	int             due_cycle     [0:max_lines-1];
	bit             cancelled     [0:max_lines-1];

	int line_count = 0;
	int pending[$];
	int cyc = 0;
	int run_cycles = 0;
	int cycle_limit = 1000;
	int pass_count = 0;
	int fail_count = 0;
	int mon_idx;

	pipelined_div dut_i (
		.clock        (clock),
		.reset        (reset),
		.remove       (remove),
		.in_valid     (in_valid),
		.in_signed    (in_signed),
		.in_dividend  (in_dividend),
		.in_divisor   (in_divisor),
		.out_valid    (out_valid),
		.out_quotient (out_quotient),
		.out_remainder(out_remainder)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cyc <= cyc + 1;
	end

	// Watchdog counting cycles after reset
	always @(posedge clock) begin
		if (!reset) begin
			run_cycles <= run_cycles + 1;
			if (run_cycles >= cycle_limit) begin
				$display("Timeout after %0d cycles, results still pending", run_cycles);
				$display("Finished with errors");
				$finish;
			end
		end
	end

	task automatic load_vectors();
		int fd;
		int code;
		int sgn;
		reg [8*16-1:0]  tok;
		reg [8*16-1:0]  op;
		reg [8*160-1:0] skip_buf;
		div_pkg::data_t dvd;
		div_pkg::data_t dvs;
		div_pkg::data_t q;
		div_pkg::data_t r;
		fd = $fopen("div_test_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open div_test_input.txt");
		end else begin
			while (!$feof(fd) && line_count < max_lines) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1 && tok == "#") begin
					code = $fgets(skip_buf, fd);
				end else if (code == 1) begin
					code = $fscanf(fd, "%s %d %h %h %h %h", op, sgn, dvd, dvs, q, r);
					if (code != 6) begin
						$display("Malformed data line for test %0s", tok);
						fail_count++;
					end else begin
						test_name[line_count] = tok;
						if (op == "divide")
							op_code[line_count] = op_divide;
						else if (op == "flush")
							op_code[line_count] = op_flush;
						else if (op == "idle")
							op_code[line_count] = op_idle;
						else begin
							$display("Unknown operation %0s for test %0s", op, tok);
							fail_count++;
							op_code[line_count] = op_idle;
						end
						signed_flag[line_count]   = (sgn != 0);
						dividend_v[line_count]    = dvd;
						divisor_v[line_count]     = dvs;
						exp_quotient[line_count]  = q;
						exp_remainder[line_count] = r;
						cancelled[line_count]     = 1'b0;
						line_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_result(input int idx);
		bit ok;
		ok = 1'b1;
		if (cyc != due_cycle[idx]) begin
			$display("%0s: result arrived at cycle %0d, expected at cycle %0d",
				test_name[idx], cyc, due_cycle[idx]);
			ok = 1'b0;
		end
		if (out_quotient !== exp_quotient[idx]) begin
			$display("MISMATCH %0s quotient expected %h actual %h",
				test_name[idx], exp_quotient[idx], out_quotient);
			ok = 1'b0;
		end
		if (out_remainder !== exp_remainder[idx]) begin
			$display("MISMATCH %0s remainder expected %h actual %h",
				test_name[idx], exp_remainder[idx], out_remainder);
			ok = 1'b0;
		end
		if (ok) begin
			pass_count++;
			$display("PASS %0s", test_name[idx]);
		end else begin
			fail_count++;
			$display("FAIL %0s", test_name[idx]);
		end
	endtask

	// Result monitor on the falling edge
	always @(negedge clock) begin
		if (out_valid === 1'b1) begin
			if (pending.size() == 0) begin
				$display("out_valid high at cycle %0d with no division pending", cyc);
				fail_count++;
			end else begin
				mon_idx = pending.pop_front();
				if (cancelled[mon_idx]) begin
					$display("Result appeared for flushed division %0s", test_name[mon_idx]);
					fail_count++;
				end else begin
					check_result(mon_idx);
				end
			end
		end
		while (pending.size() != 0 && due_cycle[pending[0]] <= cyc) begin
			mon_idx = pending.pop_front();
			if (cancelled[mon_idx]) begin
				pass_count++;
				$display("PASS %0s cancelled by flush", test_name[mon_idx]);
			end else begin
				fail_count++;
				$display("No result for %0s by cycle %0d", test_name[mon_idx], cyc);
			end
		end
	end

	task automatic run_vectors();
		int ncancel;
		for (int i = 0; i < line_count; i++) begin
			@(posedge clock);
			#2;
			in_valid = 1'b0;
			remove   = 1'b0;
			if (op_code[i] == op_divide) begin
				in_valid    = 1'b1;
				in_signed   = signed_flag[i];
				in_dividend = dividend_v[i];
				in_divisor  = divisor_v[i];
				due_cycle[i] = cyc + div_pkg::div_latency;
				pending.push_back(i);
			end else if (op_code[i] == op_flush) begin
				remove = 1'b1;
				ncancel = 0;
				// Results already on the output are not cancelled
				foreach (pending[k]) begin
					if (due_cycle[pending[k]] > cyc) begin
						cancelled[pending[k]] = 1'b1;
						ncancel++;
					end
				end
				$display("%0s: flush issued, %0d divisions in flight", test_name[i], ncancel);
			end
		end
		@(posedge clock);
		#2;
		in_valid = 1'b0;
		remove   = 1'b0;
	endtask

	initial begin
		reset       = 1'b1;
		remove      = 1'b0;
		in_valid    = 1'b0;
		in_signed   = 1'b0;
		in_dividend = '0;
		in_divisor  = '0;
		load_vectors();
		cycle_limit = line_count + div_pkg::div_latency + 20;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		@(negedge clock);
		if (out_valid !== 1'b0 || out_quotient !== '0 || out_remainder !== '0) begin
			$display("Outputs not cleared after reset");
			fail_count++;
		end else begin
			pass_count++;
			$display("PASS reset");
		end
		if (line_count == 0) begin
			$display("No test lines could be read from div_test_input.txt");
			fail_count++;
		end else begin
			run_vectors();
			while (pending.size() != 0)
				@(posedge clock);
			// A few more cycles to catch a stray strobe
			repeat (4) @(posedge clock);
		end
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: div_test_input.txt
# name operation signed dividend divisor quotient remainder
# values in hex, signed flag 0 or 1, one operation per cycle
idle_start idle 0 00000000 00000000 00000000 00000000
# stream cut short by a flush
fl_a divide 0 00000064 00000007 0000000e 00000002
fl_b divide 1 ffffff9c 00000007 fffffff2 fffffffe
fl_c divide 0 deadbeef 00001000 000deadb 00000eef
fl_d divide 0 00000005 00000009 00000000 00000005
fl_gap idle 0 00000000 00000000 00000000 00000000
flush_mid flush 0 00000000 00000000 00000000 00000000
# unsigned, back to back after the flush
u_basic divide 0 00000064 00000007 0000000e 00000002
u_small divide 0 00000005 00000009 00000000 00000005
u_max divide 0 ffffffff 00000001 ffffffff 00000000
u_max_div divide 0 ffffffff ffffffff 00000001 00000000
u_big divide 0 ffffffff 00010000 0000ffff 0000ffff
u_top divide 0 80000000 00000003 2aaaaaaa 00000002
u_equal divide 0 12345678 12345678 00000001 00000000
u_hex divide 0 deadbeef 00001000 000deadb 00000eef
u_high_bit divide 0 f0000000 00000010 0f000000 00000000
# signed, all four sign combinations and edge values
s_pp divide 1 00000064 00000007 0000000e 00000002
s_np divide 1 ffffff9c 00000007 fffffff2 fffffffe
s_pn divide 1 00000064 fffffff9 fffffff2 00000002
s_nn divide 1 ffffff9c fffffff9 0000000e fffffffe
s_minint divide 1 80000000 ffffffff 80000000 00000000
s_minint_2 divide 1 80000000 00000002 c0000000 00000000
s_odd divide 1 fffffff9 00000002 fffffffd ffffffff
# division by zero
z_unsigned divide 0 0000002a 00000000 ffffffff 0000002a
z_signed_neg divide 1 ffffffd6 00000000 00000001 ffffffd6
z_signed_pos divide 1 0000002a 00000000 ffffffff 0000002a
z_zero divide 0 00000000 00000000 ffffffff 00000000
# stream after a pause
idle_mid idle 0 00000000 00000000 00000000 00000000
p_a divide 0 00000fff 00000010 000000ff 0000000f
p_b divide 1 fffff001 00000010 ffffff01 fffffff1
p_c divide 0 00000001 80000000 00000000 00000001
idle_end idle 0 00000000 00000000 00000000 00000000

// File: pipelined_div.f
div_pkg.sv
div_operand_prep.sv
div_stage.sv
div_pipeline.sv
div_result_fix.sv
pipelined_div.sv
tb_pipelined_div.sv
